//--- logic/alpha_readout_top.sv
`timescale 1ns/1ns

module alpha_readout_top (
	input logic sysclk,
	input logic reset,
	input logic bus_req,
	output logic bus_ack,
	input logic bus_rw, // 1 = read
	input logic bus_reg_sel, // 0 = address 1 = data
	input host_bus_pkg::bus_half_t bus_wdata,
	output host_bus_pkg::bus_half_t bus_rdata,
	input logic data_a, // serial from the asic
	output logic trig,
	output logic [7:0] ctrl
);
	import asic_readout_pkg::*;

	reg_access_if acc ();

	trig_width_t trig_width;
	logic trigger_request;
	logic trigger_has_occurred;
	event_count_t trigger_count;
	logic sample_valid;
	sample_t sample;
	logic fifo_pop;
	logic fifo_empty;
	sample_t fifo_head;
	error_count_t overflow_count;
	error_count_t underflow_count;
	event_count_t samples_in;
	event_count_t samples_out;

	// ------------------------------
	// host side
	// ------------------------------
	host_bus_fsm u_host_bus_fsm (
		.sysclk(sysclk), .reset(reset), .bus_req(bus_req), .bus_rw(bus_rw),
		.bus_reg_sel(bus_reg_sel), .bus_wdata(bus_wdata), .bus_ack(bus_ack),
		.bus_rdata(bus_rdata), .acc(acc.fsm)
	);

	register_banks u_register_banks (
		.sysclk(sysclk), .reset(reset), .acc(acc.banks), .ctrl(ctrl),
		.trig_width(trig_width), .trigger_request(trigger_request),
		.trigger_has_occurred(trigger_has_occurred), .trigger_count(trigger_count),
		.fifo_empty(fifo_empty), .fifo_head(fifo_head), .fifo_pop(fifo_pop),
		.overflow_count(overflow_count), .underflow_count(underflow_count),
		.samples_in(samples_in), .samples_out(samples_out)
	);

	trigger_timer u_trigger_timer (
		.sysclk(sysclk), .reset(reset), .trigger_request(trigger_request),
		.trig_width(trig_width), .trig(trig),
		.trigger_has_occurred(trigger_has_occurred), .trigger_count(trigger_count)
	);

	// ------------------------------
	// asic side
	// ------------------------------
	serial_deserializer u_serial_deserializer (
		.sysclk(sysclk), .reset(reset), .data_a(data_a),
		.sample_valid(sample_valid), .sample(sample)
	);

	sample_fifo u_sample_fifo (
		.sysclk(sysclk), .reset(reset), .push(sample_valid), .push_data(sample),
		.pop(fifo_pop), .head(fifo_head), .empty(fifo_empty),
		.overflow_count(overflow_count), .underflow_count(underflow_count),
		.samples_in(samples_in), .samples_out(samples_out)
	);
endmodule

//--- logic/asic_readout_pkg.sv
package asic_readout_pkg;

	// ------------------------------
	// asic serial readout
	// ------------------------------
	localparam int sample_bits_c = 16;
	localparam int frame_bits_c = 16; // data bits after the start bit
	localparam int fifo_log2_depth_c = 4; // 16 words deep

	typedef logic [sample_bits_c-1:0] sample_t;

	// ------------------------------
	// counters and timer widths
	// ------------------------------
	typedef logic [31:0] event_count_t; // wraps
	typedef logic [7:0] error_count_t; // saturates at 255
	typedef logic [7:0] trig_width_t; // pulse width in sysclk cycles

endpackage

//--- logic/host_bus_fsm.sv
`timescale 1ns/1ns

module host_bus_fsm (
	input logic sysclk,
	input logic reset,
	input logic bus_req,
	input logic bus_rw, // 1 = read
	input logic bus_reg_sel, // 0 = address 1 = data
	input host_bus_pkg::bus_half_t bus_wdata,
	output logic bus_ack,
	output host_bus_pkg::bus_half_t bus_rdata,
	reg_access_if.fsm acc
);
	import host_bus_pkg::*;

	bus_state_e state;
	address_word_t address; // bank and offset
	logic second_half; // half counter
	logic txn_data; // current transaction is a data one
	logic txn_read;
	bus_half_t upper_half; // held until the lower half arrives
	bus_half_t lower_half; // second read half waits here

	assign acc.bank = address[bus_width_c-1 -: bank_bits_c];
	assign acc.offset = address[$bits(bank_offset_t)-1:0];

	// ------------------------------
	// handshake and strobes
	// ------------------------------
	always_ff @(posedge sysclk) begin
		acc.write_strobe <= 1'b0;
		acc.read_strobe <= 1'b0;
		if (reset) begin
			state <= bus_idle;
			bus_ack <= 1'b0;
			address <= '0;
			second_half <= 1'b0;
			txn_data <= 1'b0;
			txn_read <= 1'b0;
		end else begin
			case (state)
				bus_idle: begin
					if (bus_req) begin
						txn_data <= bus_reg_sel;
						txn_read <= bus_rw;
						state <= bus_access;
						if (!bus_reg_sel) begin
							address <= bus_wdata; // new address restarts the word
							second_half <= 1'b0;
						end else if (bus_rw) begin
							acc.read_strobe <= !second_half; // fetch on upper half only
						end else begin
							acc.write_strobe <= second_half; // commit on lower half
						end
					end
				end
				bus_access: begin
					state <= bus_fetch; // banks register rdata now
				end
				bus_fetch: begin
					bus_ack <= 1'b1;
					state <= bus_wait_req_low;
					if (txn_data) begin
						second_half <= !second_half;
						if (second_half) begin
							// word done so step the offset and keep the bank
							address[offset_bits_c-1:0] <= address[offset_bits_c-1:0] + 1'b1;
						end
					end
				end
				bus_wait_req_low: begin
					if (!bus_req) begin
						bus_ack <= 1'b0;
						state <= bus_idle;
					end
				end
				default: state <= bus_idle;
			endcase
		end
	end

	// ------------------------------
	// data word assembly
	// ------------------------------
	always_ff @(posedge sysclk) begin
		if (state == bus_idle && bus_req && bus_reg_sel && !bus_rw) begin
			if (!second_half) begin
				upper_half <= bus_wdata;
			end else begin
				acc.wdata <= {upper_half, bus_wdata};
			end
		end
		if (state == bus_fetch && txn_data && txn_read) begin
			if (!second_half) begin
				bus_rdata <= acc.rdata[2*bus_width_c-1:bus_width_c]; // upper half first
				lower_half <= acc.rdata[bus_width_c-1:0];
			end else begin
				bus_rdata <= lower_half;
			end
		end
	end
endmodule

//--- logic/host_bus_pkg.sv
package host_bus_pkg;

	// ------------------------------
	// bus and address geometry
	// ------------------------------
	localparam int bus_width_c = 16; // one transaction
	localparam int bank_bits_c = 3; // 8 banks
	localparam int offset_bits_c = 13; // offset field of the address word

	typedef logic [bus_width_c-1:0] bus_half_t;
	typedef logic [2*bus_width_c-1:0] data_word_t; // upper half goes first on the bus
	typedef logic [bank_bits_c+offset_bits_c-1:0] address_word_t;
	typedef logic [3:0] bank_offset_t; // 16 registers per bank

	// banks that exist
	// the remaining codes read 0 and ignore writes
	typedef enum logic [bank_bits_c-1:0] {
		bank_settings = 3'd0,
		bank_status   = 3'd1,
		bank_pulse    = 3'd2,
		bank_samples  = 3'd5
	} bank_e;

	typedef enum logic [1:0] {
		bus_idle,
		bus_access, // strobe cycle
		bus_fetch, // rdata valid here
		bus_wait_req_low
	} bus_state_e;

	localparam bank_offset_t pulse_trigger_c = 4'd3; // pulse bank trigger
endpackage

//--- logic/reg_access_if.sv
`timescale 1ns/1ns

// decoded register access between the bus fsm and the banks
interface reg_access_if;
	logic [2:0] bank; // top 3 address bits
	logic [3:0] offset; // register inside the bank
	logic [31:0] wdata; // full word for a write
	logic write_strobe; // single cycle
	logic read_strobe; // single cycle
	logic [31:0] rdata; // registered by the banks

	modport fsm (
		output bank,
		output offset,
		output wdata,
		output write_strobe,
		output read_strobe,
		input rdata
	);

	modport banks (
		input bank,
		input offset,
		input wdata,
		input write_strobe,
		input read_strobe,
		output rdata
	);
endinterface

//--- logic/register_banks.sv
`timescale 1ns/1ns

module register_banks (
	input logic sysclk,
	input logic reset,
	reg_access_if.banks acc,
	output logic [7:0] ctrl,
	output asic_readout_pkg::trig_width_t trig_width,
	output logic trigger_request,
	input logic trigger_has_occurred,
	input asic_readout_pkg::event_count_t trigger_count,
	input logic fifo_empty,
	input asic_readout_pkg::sample_t fifo_head,
	output logic fifo_pop,
	input asic_readout_pkg::error_count_t overflow_count,
	input asic_readout_pkg::error_count_t underflow_count,
	input asic_readout_pkg::event_count_t samples_in,
	input asic_readout_pkg::event_count_t samples_out
);
	import host_bus_pkg::*;
	import asic_readout_pkg::*;

	data_word_t settings [2**$bits(bank_offset_t)];
	data_word_t status_word;
	bank_e bank;

	assign bank = bank_e'(acc.bank); // unlisted codes fall to default

	// ------------------------------
	// settings bank
	// ------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			for (int i = 0; i < 2**$bits(bank_offset_t); i++) begin
				settings[i] <= '0;
			end
		end else if (acc.write_strobe && bank == bank_settings) begin
			settings[acc.offset] <= acc.wdata;
		end
	end

	assign ctrl = settings[0][7:0];
	assign trig_width = settings[1][$bits(trig_width_t)-1:0]; // 0 handled by the timer

	// pulse bank keeps only the trigger
	always_ff @(posedge sysclk) begin
		if (reset) begin
			trigger_request <= 1'b0;
		end else begin
			trigger_request <= acc.write_strobe && bank == bank_pulse
				&& acc.offset == pulse_trigger_c;
		end
	end

	assign fifo_pop = acc.read_strobe && bank == bank_samples; // each read pops one

	// ------------------------------
	// status words and read mux
	// ------------------------------
	always_comb begin
		case (acc.offset)
			4'd0: status_word = {8'h00, overflow_count, underflow_count, 6'b000000,
				fifo_empty, trigger_has_occurred};
			4'd1: status_word = trigger_count;
			4'd2: status_word = samples_in;
			4'd3: status_word = samples_out;
			default: status_word = '0;
		endcase
	end

	always_ff @(posedge sysclk) begin
		case (bank)
			bank_settings: acc.rdata <= settings[acc.offset];
			bank_status: acc.rdata <= status_word;
			bank_samples: acc.rdata <= fifo_empty ? '0 : data_word_t'(fifo_head); // zero extended
			default: acc.rdata <= '0; // pulse bank and unused banks
		endcase
	end
endmodule

//--- logic/sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo (
	input logic sysclk,
	input logic reset,
	input logic push,
	input asic_readout_pkg::sample_t push_data,
	input logic pop,
	output asic_readout_pkg::sample_t head,
	output logic empty,
	output asic_readout_pkg::error_count_t overflow_count,
	output asic_readout_pkg::error_count_t underflow_count,
	output asic_readout_pkg::event_count_t samples_in,
	output asic_readout_pkg::event_count_t samples_out
);
	import asic_readout_pkg::*;

	sample_t mem [2**fifo_log2_depth_c];
	logic [fifo_log2_depth_c-1:0] wr_ptr;
	logic [fifo_log2_depth_c-1:0] rd_ptr;
	logic [fifo_log2_depth_c:0] occupancy; // one extra bit for full
	logic full;
	logic push_ok;
	logic pop_ok;

	assign full = occupancy[fifo_log2_depth_c]; // msb set only at 16
	assign empty = (occupancy == '0);
	assign push_ok = push && !full;
	assign pop_ok = pop && !empty;
	assign head = mem[rd_ptr]; // fall through

	always_ff @(posedge sysclk) begin
		if (push_ok) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// ------------------------------
	// pointers and counters
	// ------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occupancy <= '0;
			overflow_count <= '0;
			underflow_count <= '0;
			samples_in <= '0;
			samples_out <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
				samples_in <= samples_in + 1'b1;
			end else if (push && overflow_count != '1) begin
				overflow_count <= overflow_count + 1'b1; // word dropped
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
				samples_out <= samples_out + 1'b1;
			end else if (pop && underflow_count != '1) begin
				underflow_count <= underflow_count + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy; // both or neither
			endcase
		end
	end
endmodule

//--- logic/serial_deserializer.sv
`timescale 1ns/1ns

module serial_deserializer (
	input logic sysclk,
	input logic reset,
	input logic data_a,
	output logic sample_valid,
	output asic_readout_pkg::sample_t sample
);
	import asic_readout_pkg::*;

	logic data_q; // input register
	logic busy; // inside a frame
	logic [$clog2(frame_bits_c)-1:0] bit_count;

	// ------------------------------
	// framing
	// ------------------------------
	always_ff @(posedge sysclk) begin
		sample_valid <= 1'b0;
		if (reset) begin
			data_q <= 1'b1; // line idles high
			busy <= 1'b0;
			bit_count <= '0;
		end else begin
			data_q <= data_a;
			if (!busy) begin
				if (!data_q) begin
					busy <= 1'b1; // start bit
					bit_count <= '0;
				end
			end else begin
				bit_count <= bit_count + 1'b1;
				if (bit_count == frame_bits_c - 1) begin
					busy <= 1'b0;
					sample_valid <= 1'b1; // word complete
				end
			end
		end
	end

	// msb first into the bottom
	always_ff @(posedge sysclk) begin
		if (busy) begin
			sample <= {sample[$bits(sample_t)-2:0], data_q};
		end
	end
endmodule

//--- logic/trigger_timer.sv
`timescale 1ns/1ns

module trigger_timer (
	input logic sysclk,
	input logic reset,
	input logic trigger_request,
	input asic_readout_pkg::trig_width_t trig_width,
	output logic trig,
	output logic trigger_has_occurred,
	output asic_readout_pkg::event_count_t trigger_count
);
	import asic_readout_pkg::*;

	trig_width_t remaining; // cycles of trig still to go

	always_ff @(posedge sysclk) begin
		if (reset) begin
			remaining <= '0;
			trigger_has_occurred <= 1'b0;
			trigger_count <= '0;
		end else if (trigger_request && remaining == '0) begin
			// accepted only while idle
			remaining <= (trig_width == '0) ? trig_width_t'(1) : trig_width;
			trigger_has_occurred <= 1'b1;
			trigger_count <= trigger_count + 1'b1;
		end else if (remaining != '0) begin
			remaining <= remaining - 1'b1;
		end
	end

	// high for exactly the loaded count
	assign trig = (remaining != '0);
endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the readout testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module alpha_readout_tb -f verilog.f -o alpha_readout_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/alpha_readout_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -qx "Simulation passed" sim.log; then
	exit 0
fi
exit 1

//--- tb/alpha_readout_sva.sv
`timescale 1ns/1ns

module alpha_readout_sva (
	input logic sysclk,
	input logic reset,
	input logic bus_req,
	input logic bus_ack,
	input logic trig
);
	// ------------------------------
	// four phase handshake
	// ------------------------------
	ack_needs_req: assert property (@(posedge sysclk) disable iff (reset)
		$rose(bus_ack) |-> bus_req)
		else $error("bus_ack rose with bus_req low");

	ack_holds_for_req: assert property (@(posedge sysclk) disable iff (reset)
		$fell(bus_ack) |-> !$past(bus_req))
		else $error("bus_ack fell while bus_req was high");

	// outputs quiet once reset has been seen
	quiet_in_reset: assert property (@(posedge sysclk)
		reset && $past(reset) |-> !trig && !bus_ack)
		else $error("trig or bus_ack high during reset");
endmodule

bind alpha_readout_top alpha_readout_sva u_sva (
	.sysclk(sysclk),
	.reset(reset),
	.bus_req(bus_req),
	.bus_ack(bus_ack),
	.trig(trig)
);

//--- tb/alpha_readout_tb.sv
`timescale 1ns/1ns

module alpha_readout_tb;
	import host_bus_pkg::*;
	import asic_readout_pkg::*;

	localparam int ack_timeout_c = 100; // cycles per handshake phase
	localparam int pulse_timeout_c = 400;

	logic sysclk;
	logic reset;
	logic bus_req;
	logic bus_ack;
	logic bus_rw;
	logic bus_reg_sel;
	bus_half_t bus_wdata;
	bus_half_t bus_rdata;
	logic data_a;
	logic trig;
	logic [7:0] ctrl;

	int errors = 0;
	int timeouts = 0;
	int run_len = 0; // current trig high run
	int last_run = 0; // length of the last finished pulse
	int pulses_seen = 0;
	int pulses_checked = 0;

	alpha_readout_top u_dut (.*);

	always #5 sysclk = ~sysclk;

	// trig pulse monitor
	always @(posedge sysclk) begin
		if (trig) begin
			run_len <= run_len + 1;
		end else if (run_len != 0) begin
			last_run <= run_len; // pulse just ended
			pulses_seen <= pulses_seen + 1;
			run_len <= 0;
		end
	end

	// ------------------------------
	// checks and waits
	// ------------------------------
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(negedge sysclk); // outputs settled here
			cycles++;
		end while (bus_ack !== level && cycles < ack_timeout_c);
		assert (bus_ack === level) else begin
			$display("bus_ack did not go to %0b within %0d cycles", level, cycles);
			timeouts++;
		end
	endtask

	task automatic wait_pulse(input string name, input logic [31:0] width);
		int cycles;
		cycles = 0;
		while (pulses_seen == pulses_checked && cycles < pulse_timeout_c) begin
			@(negedge sysclk);
			cycles++;
		end
		assert (pulses_seen != pulses_checked) else begin
			$display("no trig pulse seen for %s", name);
			timeouts++;
		end
		if (pulses_seen != pulses_checked) begin
			check_value(name, width, last_run);
			pulses_checked = pulses_seen;
		end
	endtask

	// ------------------------------
	// host bus
	// ------------------------------
	task automatic handshake_half(input logic rw, input logic sel, input bus_half_t wdata,
			output bus_half_t rdata);
		@(posedge sysclk);
		bus_rw <= rw;
		bus_reg_sel <= sel;
		bus_wdata <= wdata;
		bus_req <= 1'b1;
		wait_ack(1'b1);
		rdata = bus_rdata; // valid while ack is high
		@(posedge sysclk);
		bus_req <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic load_address(input address_word_t addr);
		bus_half_t unused;
		handshake_half(1'b0, 1'b0, addr, unused);
	endtask

	task automatic bus_write_word(input data_word_t word);
		bus_half_t unused;
		handshake_half(1'b0, 1'b1, word[31:16], unused); // upper half first
		handshake_half(1'b0, 1'b1, word[15:0], unused);
	endtask

	task automatic bus_read_word(output data_word_t word);
		handshake_half(1'b1, 1'b1, '0, word[31:16]);
		handshake_half(1'b1, 1'b1, '0, word[15:0]);
	endtask

	// idle gap, start bit, 16 bits msb first
	task automatic send_frame(input sample_t word);
		int gap;
		gap = 1 + $urandom % 8;
		repeat (gap) begin
			@(posedge sysclk);
			data_a <= 1'b1;
		end
		@(posedge sysclk);
		data_a <= 1'b0;
		for (int i = frame_bits_c - 1; i >= 0; i--) begin
			@(posedge sysclk);
			data_a <= word[i];
		end
		@(posedge sysclk);
		data_a <= 1'b1;
		repeat (4) @(posedge sysclk); // let the word reach the fifo
	endtask

	// ------------------------------
	// test file commands
	// ------------------------------
	task automatic run_command(input string cmd, input string name, input logic [31:0] addr,
			input logic [31:0] value, input logic [31:0] step, input logic [31:0] count);
		data_word_t word;
		case (cmd)
			"c": check_value(name, value, {24'h0, ctrl});
			"p": wait_pulse(name, value);
			"w": begin
				load_address(addr[15:0]);
				for (int i = 0; i < count; i++) begin
					bus_write_word(value + step * i); // offset steps by itself
				end
			end
			"r": begin
				load_address(addr[15:0]);
				for (int i = 0; i < count; i++) begin
					bus_read_word(word);
					check_value(name, value + step * i, word);
				end
			end
			"s": begin
				for (int i = 0; i < count; i++) begin
					send_frame(sample_t'(value + step * i));
				end
			end
			default: begin
				$display("unknown command %s in the test file", cmd);
				errors++;
			end
		endcase
	endtask

	initial begin
		int fd;
		int fields;
		string line;
		string cmd;
		string name;
		logic [31:0] addr;
		logic [31:0] value;
		logic [31:0] step;
		logic [31:0] count;
		sysclk = 1'b0;
		reset = 1'b1;
		bus_req = 1'b0;
		bus_rw = 1'b0;
		bus_reg_sel = 1'b0;
		bus_wdata = '0;
		data_a = 1'b1; // serial line idles high
		void'($urandom(90));
		repeat (16) @(posedge sysclk);
		reset <= 1'b0;
		@(posedge sysclk);
		fd = $fopen("tb/alpha_readout_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open tb/alpha_readout_tests.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				fields = $sscanf(line, "%s %s %h %h %h %h", cmd, name, addr, value, step, count);
				if (fields == 6 && cmd != "#") begin
					run_command(cmd, name, addr, value, step, count);
				end
			end
			$fclose(fd);
		end
		$display("checks done with %0d errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end
endmodule

//--- tb/alpha_readout_tests.txt
# cmd name addr value step count, numbers in hex
# w/r load addr then move value+i*step over count words, c ctrl, p trig width, s frames
c rst_ctrl 0 0 0 1
r rst_settings 0000 0 0 10
r rst_status 2000 2 0 1
w set_run 0000 a5 11111111 4
r set_back 0000 a5 11111111 4
c set_ctrl 0 a5 0 1
w trig_width5 0001 5 0 1
w trig_fire5 4003 0 0 1
p trig_pulse5 0 5 0 1
w trig_width0 0001 0 0 1
w trig_fire0 4003 0 0 1
p trig_pulse0 0 1 0 1
r trig_status 2000 3 0 1
r trig_count 2001 2 0 1
s order_frames 0 1234 1111 5
r order_read a000 1234 1111 5
r order_counts 2002 5 0 2
r empty_read a000 0 0 1
r empty_status 2000 103 0 1
s over_frames 0 100 1 12
r over_read a000 100 1 10
r over_status 2000 20103 0 1
r over_counts 2002 15 0 2

//--- verilog.f
logic/host_bus_pkg.sv
logic/asic_readout_pkg.sv
logic/reg_access_if.sv
logic/host_bus_fsm.sv
logic/register_banks.sv
logic/trigger_timer.sv
logic/serial_deserializer.sv
logic/sample_fifo.sv
logic/alpha_readout_top.sv
tb/alpha_readout_sva.sv
tb/alpha_readout_tb.sv
